// ==== Makefile ====
# the binary is rebuilt only when the file list or a source changes
SIM := obj_dir/Vtb_zports

.PHONY: all run clean

all: run

$(SIM): zports.f $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_zports -f zports.f

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

// ==== sim/tb_zports.sv ====
// testbench for the port block with reference model, bus tasks and strobe monitor
`timescale 1ns/100ps
`include "zports_macros.svh"

module tb_zports;

  import zbus_pkg::*;

  // six tests of up to 40 accesses at 6 cycles each plus margin
  localparam int max_cycles = 4000;

  localparam logic [7:0] xt_idx [0:8] = '{
    `XT_RAMPAGE, `XT_RAMPAGE + 8'd1, `XT_RAMPAGE + 8'd2, `XT_RAMPAGE + 8'd3,
    `XT_SYSCONF, `XT_MEMCONF, `XT_INTMASK, `XT_CACHECONF, `XT_FMADDR
  };

  logic        clk;
  logic        rst;
  port_addr_u  a;
  logic [7:0]  din;
  logic        iord;
  logic        iowr;
  logic        opfetch;
  logic        dos;
  logic [4:0]  keys_in;
  logic        tape_read;
  logic [4:0]  kj_in;
  logic [7:0]  mus_in;
  logic [7:0]  sd_dataout;
  logic [7:0]  dout;
  logic        dataout;
  logic        porthit;
  logic        border_wr;
  logic        beeper_wr;
  logic        sd_start;
  logic [7:0]  sd_datain;
  logic        sdcs_n;
  logic        sd2cs_n;
  logic [31:0] xt_page;
  logic [7:0]  memconf;
  logic [7:0]  sysconf;
  logic [3:0]  cacheconf;
  logic [7:0]  intmask;
  logic [4:0]  fmaddr;

  // reference model state
  logic [7:0]  m_page [0:3];
  logic [7:0]  m_memconf;
  logic [7:0]  m_sysconf;
  logic [3:0]  m_cache;
  logic [7:0]  m_intmask;
  logic [4:0]  m_fmaddr;
  logic        m_lock48;
  logic        m_m1;
  logic        m_pwr;

  logic [15:0] lfsr = 16'd59;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          border_cnt = 0;
  int          beeper_cnt = 0;
  int          start_cnt = 0;

  zports_top dut (
    .clk (clk), .rst (rst), .a (a), .din (din), .iord (iord), .iowr (iowr),
    .opfetch (opfetch), .dos (dos), .keys_in (keys_in), .tape_read (tape_read),
    .kj_in (kj_in), .mus_in (mus_in), .sd_dataout (sd_dataout), .dout (dout),
    .dataout (dataout), .porthit (porthit), .border_wr (border_wr),
    .beeper_wr (beeper_wr), .sd_start (sd_start), .sd_datain (sd_datain),
    .sdcs_n (sdcs_n), .sd2cs_n (sd2cs_n), .xt_page (xt_page), .memconf (memconf),
    .sysconf (sysconf), .cacheconf (cacheconf), .intmask (intmask), .fmaddr (fmaddr)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    int         i;
    r = 8'h00;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      r = {r[6:0], lfsr[0]};  // one step per bit
    end
    return r;
  endfunction

  function automatic logic [7:0] page3_rule(input logic [7:0] d, input logic [7:0] mc,
                                            input logic m1);
    logic [2:0] hi;
    case (mc[7:6])
      2'd3:    hi = {d[5], d[7], d[6]};
      2'd2:    hi = m1 ? 3'b000 : {1'b0, d[7], d[6]};
      default: hi = mc[6] ? 3'b000 : {1'b0, d[7], d[6]};
    endcase
    return {2'b00, hi, d[2:0]};
  endfunction

  function automatic logic port_is_hit(input logic [7:0] port, input logic dos_in);
    case (port)
      `PORT_FE, `PORT_XT, `PORT_FD, `PORT_KMOUSE, `PORT_SDCFG, `PORT_SDDAT: return 1'b1;
      `PORT_KJOY: return !dos_in;  // floppy owns #1F under dos
      default:    return 1'b0;
    endcase
  endfunction

  function automatic logic [7:0] expected_read(input logic [15:0] adr);
    case (adr[7:0])
      `PORT_FE:     return {1'b1, tape_read, 1'b1, keys_in};
      `PORT_KJOY:   return dos ? 8'hFF : {3'b000, kj_in};
      `PORT_KMOUSE: return mus_in;
      `PORT_SDCFG:  return 8'h00;
      `PORT_SDDAT:  return sd_dataout;
      `PORT_XT:
      begin
        if (adr[15:8] == `XT_STAT)
          return {1'b0, m_pwr, 6'b000000};
        else if (adr[15:8] == `XT_RAMPAGE + 8'd2)
          return m_page[2];
        else if (adr[15:8] == `XT_RAMPAGE + 8'd3)
          return m_page[3];
        else
          return 8'hFF;
      end
      default:      return 8'hFF;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic reset_model();
    m_page[0] = `RST_PAGE0;
    m_page[1] = `RST_PAGE1;
    m_page[2] = `RST_PAGE2;
    m_page[3] = `RST_PAGE3;
    m_memconf = `RST_MEMCONF;
    m_intmask = `RST_INTMASK;
    m_sysconf = 8'h00;
    m_cache   = 4'h0;
    m_fmaddr  = 5'h00;
    m_lock48  = 1'b0;
    m_m1      = 1'b0;
    m_pwr     = 1'b1;
  endtask

  task automatic apply_xt(input logic [7:0] idx, input logic [7:0] d);
    if (idx[7:2] == 6'(`XT_RAMPAGE >> 2))
      m_page[idx[1:0]] = d;
    if (idx == `XT_FMADDR)
      m_fmaddr = d[4:0];
    if (idx == `XT_SYSCONF)
    begin
      m_sysconf = d;
      m_cache = {4{d[2]}};
    end
    if (idx == `XT_CACHECONF)
      m_cache = d[3:0];
    if (idx == `XT_MEMCONF)
      m_memconf = d;
    if (idx == `XT_INTMASK)
      m_intmask = d;
  endtask

  task automatic apply_7ffd(input logic [15:0] adr, input logic [7:0] d);
    if (!adr[15] && !m_lock48)
    begin
      m_page[3] = page3_rule(d, m_memconf, m_m1);
      if (d[5] && (m_memconf[7:6] != 2'd3))
        m_lock48 = 1'b1;
      m_memconf[0] = d[4];
    end
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic io_write(input logic [15:0] adr, input logic [7:0] d);
    a = adr;
    din = d;
    iowr = 1'b1;
    idle(4);
    iowr = 1'b0;
    idle(2);
  endtask

  task automatic io_read(input logic [15:0] adr, output logic [7:0] d);
    a = adr;
    iord = 1'b1;
    idle(3);
    @(negedge clk);
    d = dout;  // sampled at the end of the access like the cpu
    idle(1);
    iord = 1'b0;
    idle(2);
  endtask

  task automatic write_xt(input logic [7:0] idx, input logic [7:0] d);
    io_write({idx, `PORT_XT}, d);
    apply_xt(idx, d);
  endtask

  task automatic write_7ffd(input logic [15:0] adr, input logic [7:0] d);
    io_write(adr, d);
    apply_7ffd(adr, d);
  endtask

  task automatic read_check(input string name, input logic [15:0] adr);
    logic [7:0] exp;
    logic [7:0] got;
    exp = expected_read(adr);
    io_read(adr, got);
    check(name, 32'(exp), 32'(got));
    if (adr == {`XT_STAT, `PORT_XT})
      m_pwr = 1'b0;
  endtask

  task automatic fetch(input logic [7:0] op);
    din = op;
    opfetch = 1'b1;
    idle(1);
    opfetch = 1'b0;
    m_m1 = (op[7] == op[6]);
  endtask

  task automatic check_regs(input string name);
    check(name, {m_page[3], m_page[2], m_page[1], m_page[0]}, xt_page);
    check(name, 32'(m_memconf), 32'(memconf));
    check(name, 32'(m_sysconf), 32'(sysconf));
    check(name, 32'(m_cache), 32'(cacheconf));
    check(name, 32'(m_intmask), 32'(intmask));
    check(name, 32'(m_fmaddr), 32'(fmaddr));
  endtask

  task automatic do_reset();
    rst = 1'b1;
    idle(8);
    rst = 1'b0;
    reset_model();
  endtask

  // strobe counters and per cycle bus checks
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (border_wr) border_cnt++;
      if (beeper_wr) beeper_cnt++;
      if (sd_start)  start_cnt++;
      check("porthit", 32'(port_is_hit(a.xt.port, dos)), 32'(porthit));
      check("dataout", 32'(port_is_hit(a.xt.port, dos) && iord), 32'(dataout));
      check("sd_datain", 32'(iowr ? din : 8'hFF), 32'(sd_datain));
      if (!iord && !iowr)
        check("idle strobes", 32'h0, 32'({border_wr, beeper_wr, sd_start, dataout}));
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("timeout after %0d cycles, %0d errors so far", cycles, errors);
      $display("Done: errors found");
      $finish;
    end
  end

  initial
  begin
    logic [7:0] d;
    int         i;
    int         m;
    int         k;
    int         n0;
    int         n1;
    rst = 1'b1;
    a = 16'h0000;
    din = 8'h00;
    iord = 1'b0;
    iowr = 1'b0;
    opfetch = 1'b0;
    dos = 1'b0;
    keys_in = 5'h1F;
    tape_read = 1'b0;
    kj_in = 5'h00;
    mus_in = 8'hFF;
    sd_dataout = 8'hFF;
    do_reset();

    // reset values and power-up flag
    check_regs("reset regs");
    check("reset sdcs_n", 32'h1, 32'(sdcs_n));
    check("reset sd2cs_n", 32'h1, 32'(sd2cs_n));
    read_check("status first", {`XT_STAT, `PORT_XT});
    read_check("status second", {`XT_STAT, `PORT_XT});

    // extended registers
    for (i = 0; i < 24; i++)
    begin
      k = int'(rand_bits(4)) % 9;
      write_xt(xt_idx[k], rand_bits(8));
      check_regs("xt write");
    end
    read_check("page2 read", {`XT_RAMPAGE + 8'd2, `PORT_XT});
    read_check("page3 read", {`XT_RAMPAGE + 8'd3, `PORT_XT});
    write_xt(`XT_SYSCONF, 8'h04);
    check("cacheconf copy set", 32'hF, 32'(cacheconf));
    write_xt(`XT_SYSCONF, 8'hFB);
    check("cacheconf copy clear", 32'h0, 32'(cacheconf));

    // 7ffd paging in every lock mode, bit 5 kept low below mode 3
    for (m = 3; m >= 0; m--)
    begin
      write_xt(`XT_MEMCONF, {2'(m), 6'b000100});
      for (i = 0; i < 8; i++)
      begin
        if (m == 2 && i == 0)
          fetch(8'h3E);  // bits 7,6 equal so locked
        if (m == 2 && i == 4)
          fetch(8'hBE);
        d = rand_bits(8);
        if (m != 3)
          d[5] = 1'b0;
        write_7ffd(16'h7FFD, d);
        check_regs("7ffd write");
      end
    end
    write_7ffd(16'hFFFD, rand_bits(8));
    check_regs("7ffd a15 high");
    write_7ffd(16'h7FFD, 8'h23);  // sets lock48 in mode 0
    write_7ffd(16'h7FFD, 8'h07);
    write_7ffd(16'h7FFD, 8'hD1);
    check_regs("7ffd locked");
    do_reset();
    check_regs("reset after lock");
    write_7ffd(16'h7FFD, 8'h16);
    check_regs("7ffd after reset");

    // readback of peripheral ports, dos high in the last round
    for (i = 0; i < 4; i++)
    begin
      d = rand_bits(5);
      keys_in = d[4:0];
      d = rand_bits(1);
      tape_read = d[0];
      d = rand_bits(5);
      kj_in = d[4:0];
      mus_in = rand_bits(8);
      sd_dataout = rand_bits(8);
      dos = (i == 3);
      read_check("read fe", {rand_bits(8), `PORT_FE});
      read_check("read 1f", {rand_bits(8), `PORT_KJOY});
      read_check("read df", {rand_bits(8), `PORT_KMOUSE});
      read_check("read 57", {rand_bits(8), `PORT_SDDAT});
      read_check("read 77", {rand_bits(8), `PORT_SDCFG});
      read_check("read unknown", 16'h1234);
    end
    dos = 1'b0;

    // strobes
    n0 = border_cnt;
    n1 = beeper_cnt;
    for (i = 0; i < 5; i++)
      io_write({rand_bits(8), `PORT_FE}, rand_bits(8));
    check("border pulses", 32'(n0 + 5), 32'(border_cnt));
    check("beeper pulses", 32'(n1 + 5), 32'(beeper_cnt));
    for (i = 0; i < 4; i++)
    begin
      d = rand_bits(8);
      io_write(16'h0077, d);
      check("sdcs_n", 32'(d[1]), 32'(sdcs_n));
      check("sd2cs_n", 32'(d[2]), 32'(sd2cs_n));
    end
    n0 = start_cnt;
    for (i = 0; i < 3; i++)
    begin
      io_write(16'h0057, rand_bits(8));
      read_check("sd data read", 16'h0057);
    end
    check("sd_start pulses", 32'(n0 + 6), 32'(start_cnt));

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== verilog/mem_paging.sv ====
// classic #7FFD paging with 128K lock modes and the 48K lock bit
`timescale 1ns/100ps

module mem_paging (
  input  logic                 clk,
  input  logic                 rst,
  input  zbus_pkg::port_addr_u a,
  input  logic [7:0]           din,
  input  logic                 opfetch,
  input  logic                 p7ffd_wr_req,
  input  logic [7:0]           memconf,
  output logic                 page3_wr,
  output logic [7:0]           page3_val,
  output logic                 rom_sel
);

  import zcfg_pkg::*;

  logic [1:0] mode;
  logic       m1_lock;   // opcode based lock for mode 2
  logic       lock48;

  assign mode = lock_mode(memconf);

  // partial decode, a15 low only
  assign page3_wr  = p7ffd_wr_req && !a.lines.a15 && !lock48;
  assign page3_val = page_from_7ffd(din, mode, m1_lock);
  assign rom_sel   = din[4];

  always_ff @(posedge clk)
  begin
    if (rst)
      m1_lock <= 1'b0;
    else if (opfetch)
      m1_lock <= (din[7] == din[6]);  // opcode byte on the bus
  end

  // once set, paging stays frozen until reset
  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (page3_wr && din[5] && (mode != 2'd3))
      lock48 <= 1'b1;
  end

endmodule

// ==== verilog/port_readback.sv ====
// read data multiplexer, dataout and the power-up flag
`timescale 1ns/100ps
`include "zports_macros.svh"

module port_readback (
  input  logic                 clk,
  input  logic                 rst,
  input  zbus_pkg::port_addr_u a,
  input  logic                 iord,
  input  logic                 port_rd,
  input  logic                 porthit,
  input  logic                 dos,
  input  logic [31:0]          xt_page,
  input  logic [4:0]           keys_in,
  input  logic                 tape_read,
  input  logic [4:0]           kj_in,
  input  logic [7:0]           mus_in,
  input  logic [7:0]           sd_dataout,
  output logic [7:0]           dout,
  output logic                 dataout
);

  import zcfg_pkg::*;

  logic pwr_up;
  logic pwr_up_reg;  // value seen by the last status read
  logic stat_rd;

  assign stat_rd = port_rd && (a.xt.port == `PORT_XT) && (a.xt.idx == `XT_STAT);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pwr_up     <= 1'b1;
      pwr_up_reg <= 1'b1;
    end
    else if (stat_rd)
    begin
      pwr_up_reg <= pwr_up;
      pwr_up     <= 1'b0;
    end
  end

  assign dataout = porthit && iord;

  always_comb
  begin
    case (a.xt.port)
      `PORT_FE:     dout = {1'b1, tape_read, 1'b1, keys_in};
      `PORT_KJOY:   dout = dos ? 8'hFF : {3'b000, kj_in};
      `PORT_KMOUSE: dout = mus_in;
      `PORT_SDCFG:  dout = 8'h00;  // card present, not write protected
      `PORT_SDDAT:  dout = sd_dataout;
      `PORT_XT:
      begin
        case (a.xt.idx)
          `XT_STAT:                           dout = status_byte(pwr_up_reg);
          `XT_RAMPAGE + 8'd2, `XT_RAMPAGE + 8'd3: dout = xt_page[{a.xt.idx[1:0], 3'b000} +: 8];
          default:                            dout = 8'hFF;
        endcase
      end
      default:      dout = 8'hFF;
    endcase
  end

endmodule

// ==== verilog/xt_regs.sv ====
// extended #nnAF register file with ram pages and configuration registers
`timescale 1ns/100ps
`include "zports_macros.svh"

module xt_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  zbus_pkg::port_addr_u a,
  input  logic [7:0]           din,
  input  logic                 xt_wr,
  input  logic                 page3_wr,
  input  logic [7:0]           page3_val,
  input  logic                 rom_sel,
  output logic [31:0]          xt_page,
  output logic [7:0]           memconf,
  output logic [7:0]           sysconf,
  output logic [3:0]           cacheconf,
  output logic [7:0]           intmask,
  output logic [4:0]           fmaddr
);

  localparam logic [7:0] rampage_base = `XT_RAMPAGE;

  logic [7:0] page [0:3];
  logic [7:0] idx;

  assign idx     = a.xt.idx;
  assign xt_page = {page[3], page[2], page[1], page[0]};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      page[0]   <= `RST_PAGE0;
      page[1]   <= `RST_PAGE1;
      page[2]   <= `RST_PAGE2;
      page[3]   <= `RST_PAGE3;
      memconf   <= `RST_MEMCONF;
      intmask   <= `RST_INTMASK;
      sysconf   <= 8'h00;  // 3.5 MHz
      cacheconf <= 4'h0;
      fmaddr    <= 5'h00;
    end
    else if (page3_wr)  // #7FFD wins over #nnAF
    begin
      page[3]    <= page3_val;
      memconf[0] <= rom_sel;
    end
    else if (xt_wr)
    begin
      if (idx[7:2] == rampage_base[7:2])
        page[idx[1:0]] <= din;

      if (idx == `XT_FMADDR)
        fmaddr <= din[4:0];

      if (idx == `XT_SYSCONF)
      begin
        sysconf   <= din;
        cacheconf <= {4{din[2]}};  // turbo bit enables all cache windows
      end

      if (idx == `XT_CACHECONF)
        cacheconf <= din[3:0];

      if (idx == `XT_MEMCONF)
        memconf <= din;

      if (idx == `XT_INTMASK)
        intmask <= din;
    end
  end

endmodule

// ==== verilog/zbus_pkg.sv ====
// port address union with the #nnAF view and the single line view
package zbus_pkg;

  // one 16-bit z80 port address, read two ways
  typedef union packed {
    struct packed {
      logic [7:0] idx;   // register index of #nnAF
      logic [7:0] port;
    } xt;
    struct packed {
      logic       a15;   // must be low for #7FFD
      logic       a14;
      logic [5:0] mid;
      logic [7:0] port;
    } lines;
  } port_addr_u;

endpackage

// ==== verilog/zcfg_pkg.sv ====
// lock mode, #7FFD page byte and status byte functions
package zcfg_pkg;

  function automatic logic [1:0] lock_mode(input logic [7:0] memconf);
    return memconf[7:6];
  endfunction

  function automatic logic [7:0] page_from_7ffd(input logic [7:0] data,
                                                input logic [1:0] mode,
                                                input logic       m1_lock);
    logic       lock128;
    logic [2:0] hi;
    // in modes 0 and 1 memconf bit 6 is mode bit 0
    lock128 = (mode == 2'd2) ? m1_lock : mode[0];
    if (mode == 2'd3)
      hi = {data[5], data[7:6]};  // 1024K, no lock
    else
      hi = {1'b0, lock128 ? 2'b00 : data[7:6]};
    return {2'b00, hi, data[2:0]};
  endfunction

  function automatic logic [7:0] status_byte(input logic pwr_up);
    return {1'b0, pwr_up, 6'b000000};
  endfunction

endpackage

// ==== verilog/zport_decode.sv ====
// strobe edge detection, port hit decode, access strobes and sd chip select register
`timescale 1ns/100ps
`include "zports_macros.svh"

module zport_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  zbus_pkg::port_addr_u a,
  input  logic [7:0]           din,
  input  logic                 iord,
  input  logic                 iowr,
  input  logic                 dos,
  output logic                 port_rd,
  output logic                 port_wr,
  output logic                 xt_wr,
  output logic                 p7ffd_wr_req,
  output logic                 border_wr,
  output logic                 beeper_wr,
  output logic                 porthit,
  output logic                 sd_start,
  output logic [7:0]           sd_datain,
  output logic                 sdcs_n,
  output logic                 sd2cs_n
);

  logic       iord_r;
  logic       iowr_r;
  logic [7:0] lo;

  assign lo = a.xt.port;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      iord_r <= 1'b0;
      iowr_r <= 1'b0;
    end
    else
    begin
      iord_r <= iord;
      iowr_r <= iowr;
    end
  end

  assign port_rd = iord && !iord_r;  // first cycle of the read level
  assign port_wr = iowr && !iowr_r;

  assign xt_wr        = port_wr && (lo == `PORT_XT);
  assign p7ffd_wr_req = port_wr && (lo == `PORT_FD);  // a15 and lock checked in paging
  assign border_wr    = port_wr && (lo == `PORT_FE);
  assign beeper_wr    = port_wr && (lo == `PORT_FE);

  // #1F belongs to the floppy controller while dos is active
  assign porthit = (lo == `PORT_FE) || (lo == `PORT_XT) || (lo == `PORT_FD)
                || (lo == `PORT_KMOUSE) || (lo == `PORT_SDCFG) || (lo == `PORT_SDDAT)
                || ((lo == `PORT_KJOY) && !dos);

  // spi engine kicks off on any data port access
  assign sd_start  = (port_wr || port_rd) && (lo == `PORT_SDDAT);
  assign sd_datain = iowr ? din : 8'hFF;  // reads shift out all ones

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sdcs_n  <= 1'b1;
      sd2cs_n <= 1'b1;
    end
    else if (port_wr && (lo == `PORT_SDCFG))
    begin
      sdcs_n  <= din[1];
      sd2cs_n <= din[2];
    end
  end

endmodule

// ==== verilog/zports_macros.svh ====
// port numbers, extended register indices and reset values of the port block
`ifndef ZPORTS_MACROS_SVH
`define ZPORTS_MACROS_SVH

// low address byte of the decoded ports
`define PORT_FE       8'hFE  // keyboard, border, beeper
`define PORT_FD       8'hFD  // 128K paging at #7FFD
`define PORT_XT       8'hAF  // extended registers #nnAF
`define PORT_KJOY     8'h1F  // kempston joystick
`define PORT_KMOUSE   8'hDF  // kempston mouse
`define PORT_SDCFG    8'h77  // sd chip select
`define PORT_SDDAT    8'h57  // sd data

// high address byte of #nnAF
`define XT_STAT       8'h00  // status, read only
`define XT_RAMPAGE    8'h10  // pages #10..#13
`define XT_FMADDR     8'h15
`define XT_SYSCONF    8'h20
`define XT_MEMCONF    8'h21
`define XT_INTMASK    8'h2A
`define XT_CACHECONF  8'h2B

// register values after reset
`define RST_MEMCONF   8'h04  // no rom mapping
`define RST_INTMASK   8'h01  // frame interrupt only
`define RST_PAGE0     8'h00
`define RST_PAGE1     8'h05
`define RST_PAGE2     8'h02
`define RST_PAGE3     8'h00

`endif

// ==== verilog/zports_top.sv ====
// top level of the port block wiring decode, paging, registers and readback
`timescale 1ns/100ps

module zports_top (
  input  logic                 clk,
  input  logic                 rst,
  input  zbus_pkg::port_addr_u a,
  input  logic [7:0]           din,
  input  logic                 iord,
  input  logic                 iowr,
  input  logic                 opfetch,
  input  logic                 dos,
  input  logic [4:0]           keys_in,
  input  logic                 tape_read,
  input  logic [4:0]           kj_in,
  input  logic [7:0]           mus_in,
  input  logic [7:0]           sd_dataout,
  output logic [7:0]           dout,
  output logic                 dataout,
  output logic                 porthit,
  output logic                 border_wr,
  output logic                 beeper_wr,
  output logic                 sd_start,
  output logic [7:0]           sd_datain,
  output logic                 sdcs_n,
  output logic                 sd2cs_n,
  output logic [31:0]          xt_page,
  output logic [7:0]           memconf,
  output logic [7:0]           sysconf,
  output logic [3:0]           cacheconf,
  output logic [7:0]           intmask,
  output logic [4:0]           fmaddr
);

  logic       port_rd;
  logic       port_wr;
  logic       xt_wr;
  logic       p7ffd_wr_req;
  logic       page3_wr;
  logic [7:0] page3_val;
  logic       rom_sel;

  zport_decode u_decode (
    .clk          (clk),
    .rst          (rst),
    .a            (a),
    .din          (din),
    .iord         (iord),
    .iowr         (iowr),
    .dos          (dos),
    .port_rd      (port_rd),
    .port_wr      (port_wr),
    .xt_wr        (xt_wr),
    .p7ffd_wr_req (p7ffd_wr_req),
    .border_wr    (border_wr),
    .beeper_wr    (beeper_wr),
    .porthit      (porthit),
    .sd_start     (sd_start),
    .sd_datain    (sd_datain),
    .sdcs_n       (sdcs_n),
    .sd2cs_n      (sd2cs_n)
  );

  mem_paging u_paging (
    .clk          (clk),
    .rst          (rst),
    .a            (a),
    .din          (din),
    .opfetch      (opfetch),
    .p7ffd_wr_req (p7ffd_wr_req),
    .memconf      (memconf),
    .page3_wr     (page3_wr),
    .page3_val    (page3_val),
    .rom_sel      (rom_sel)
  );

  xt_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .a         (a),
    .din       (din),
    .xt_wr     (xt_wr),
    .page3_wr  (page3_wr),
    .page3_val (page3_val),
    .rom_sel   (rom_sel),
    .xt_page   (xt_page),
    .memconf   (memconf),
    .sysconf   (sysconf),
    .cacheconf (cacheconf),
    .intmask   (intmask),
    .fmaddr    (fmaddr)
  );

  port_readback u_readback (
    .clk        (clk),
    .rst        (rst),
    .a          (a),
    .iord       (iord),
    .port_rd    (port_rd),
    .porthit    (porthit),
    .dos        (dos),
    .xt_page    (xt_page),
    .keys_in    (keys_in),
    .tape_read  (tape_read),
    .kj_in      (kj_in),
    .mus_in     (mus_in),
    .sd_dataout (sd_dataout),
    .dout       (dout),
    .dataout    (dataout)
  );

endmodule

// ==== zports.f ====
+incdir+verilog
verilog/zbus_pkg.sv
verilog/zcfg_pkg.sv
verilog/zport_decode.sv
verilog/mem_paging.sv
verilog/xt_regs.sv
verilog/port_readback.sv
verilog/zports_top.sv
sim/tb_zports.sv
